// File: logic/z8Pkg.sv
package z8Pkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;

    // Two-operand codes equal the opcode high nibble
    typedef enum logic [3:0] {
        aluAdd = 4'h0,
        aluAdc = 4'h1,
        aluSub = 4'h2,
        aluSbc = 4'h3,
        aluOr  = 4'h4,
        aluAnd = 4'h5,
        aluTcm = 4'h6,
        aluTm  = 4'h7,
        aluCp  = 4'hA,
        aluXor = 4'hB,
        aluLd  = 4'hC,
        aluInc = 4'hD,
        aluDec = 4'hE
    } aluOpE;

    typedef enum logic [3:0] {
        stFetch,
        stReadInstr,
        stWait2,
        stRead2,
        stWait3,
        stRead3,
        stDecode,
        stExecute,
        stDjnzDec,
        stDjnzBranch
    } coreStateE;

    // Same bit order as the FLAGS register, carry on top
    typedef struct packed {
        logic       c;
        logic       z;
        logic       s;
        logic       v;
        logic       d;
        logic       h;
        logic [1:0] spare;
    } flagsT;

    typedef struct packed {
        logic valid;
        byteT addr;
        byteT data;
    } regWriteT;

    typedef struct packed {
        logic strobe;
        addrT addr;
    } memReqT;

    typedef struct packed {
        logic en;
        addrT addr;
        byteT data;
    } romLoadT;

    localparam byteT       REG_FLAGS      = 8'hFC;
    localparam byteT       REG_RP         = 8'hFD;
    localparam logic [3:0] WORKING_PREFIX = 4'hE;
    localparam addrT       RESET_VECTOR   = 16'h000C;

endpackage

// File: logic/programRom.sv
`timescale 1ns/10ps

module programRom
    import z8Pkg::*;
#(
    parameter int ADDR_BITS = 13
) (
    input  logic    clk,
    input  memReqT  memReq,
    output byteT    rdData,
    input  romLoadT romLoad
);
    localparam int DEPTH = 1 << ADDR_BITS;

    byteT mem [DEPTH];

    // Upper address bits are dropped, so addresses wrap
    always_ff @(posedge clk) begin
        if (romLoad.en) begin
            mem[romLoad.addr[ADDR_BITS-1:0]] <= romLoad.data;
        end
        if (memReq.strobe) begin
            rdData <= mem[memReq.addr[ADDR_BITS-1:0]];
        end
    end

endmodule

// File: logic/z8Alu.sv
`timescale 1ns/10ps

module z8Alu
    import z8Pkg::*;
(
    input  aluOpE op,
    input  byteT  a,
    input  byteT  b,
    input  flagsT flagsIn,
    output byteT  result,
    output flagsT flagsOut
);
    logic       isSub;
    logic       useCarry;
    logic       carryIn;
    byteT       addend;
    logic [8:0] sum;
    logic       overflow;
    byteT       logicResult;

    assign isSub    = (op == aluSub) || (op == aluSbc) || (op == aluCp);
    assign useCarry = (op == aluAdc) || (op == aluSbc);

    // a - b - c computed as a + ~b + (1 - c)
    assign addend   = isSub ? ~b : b;
    assign carryIn  = isSub ? ~(useCarry & flagsIn.c) : (useCarry & flagsIn.c);
    assign sum      = {1'b0, a} + {1'b0, addend} + {8'h00, carryIn};
    assign overflow = (a[7] == addend[7]) && (sum[7] != a[7]);

    always_comb begin
        case (op)
        aluOr:   logicResult = a | b;
        aluTcm:  logicResult = ~a & b;
        aluXor:  logicResult = a ^ b;
        default: logicResult = a & b;
        endcase
    end

    always_comb begin
        result   = b;
        flagsOut = flagsIn;
        case (op)
        aluAdd, aluAdc, aluSub, aluSbc, aluCp: begin
            result = sum[7:0];
            // Borrow is the inverted carry out
            flagsOut.c = sum[8] ^ isSub;
            flagsOut.v = overflow;
        end
        aluOr, aluAnd, aluTcm, aluTm, aluXor: begin
            result     = logicResult;
            flagsOut.v = 1'b0;
        end
        aluInc: begin
            result     = a + 8'd1;
            flagsOut.v = (a == 8'h7F);
        end
        aluDec: begin
            result     = a - 8'd1;
            flagsOut.v = (a == 8'h80);
        end
        default: begin
            result = b;
        end
        endcase

        if (op != aluLd) begin
            flagsOut.z = (result == 8'h00);
            flagsOut.s = result[7];
        end
        // No decimal adjust, so D and H stay clear
        flagsOut.d = 1'b0;
        flagsOut.h = 1'b0;
    end

endmodule

// File: logic/registerFile.sv
`timescale 1ns/10ps

module registerFile
    import z8Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  byteT       rdAddrA,
    input  byteT       rdAddrB,
    output byteT       rdDataA,
    output byteT       rdDataB,
    input  regWriteT   regWrite,
    input  logic       flagsWrite,
    input  flagsT      flagsNew,
    output logic [3:0] rp,
    output flagsT      flags
);
    byteT regs [128];

    function automatic byteT readReg(input byteT addr);
        if (!addr[7]) begin
            return regs[addr[6:0]];
        end
        if (addr == REG_FLAGS) begin
            return flags;
        end
        if (addr == REG_RP) begin
            return {rp, 4'h0};
        end
        // Unmapped space reads as zero
        return 8'h00;
    endfunction

    always_comb begin
        rdDataA = readReg(rdAddrA);
        rdDataB = readReg(rdAddrB);
    end

    always_ff @(posedge clk) begin
        if (regWrite.valid && !regWrite.addr[7]) begin
            regs[regWrite.addr[6:0]] <= regWrite.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rp    <= 4'h0;
            flags <= '0;
        end else begin
            if (flagsWrite) begin
                flags <= flagsNew;
            end
            // A register write to FLAGS overrides the flag update
            if (regWrite.valid && regWrite.addr == REG_FLAGS) begin
                flags <= flagsT'({regWrite.data[7:4], 2'b00, regWrite.data[1:0]});
            end
            if (regWrite.valid && regWrite.addr == REG_RP) begin
                rp <= regWrite.data[7:4];
            end
        end
    end

endmodule

// File: logic/z8Core.sv
`timescale 1ns/10ps

module z8Core
    import z8Pkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    output memReqT   memReq,
    output logic     fetchStrobe,
    input  byteT     rdData,
    output regWriteT regWrite,
    output flagsT    flags
);
    coreStateE  state;
    addrT       pc;
    byteT       instr;
    byteT       second;
    byteT       third;
    logic [3:0] instrH;
    logic [3:0] instrL;
    logic       isSize1;
    logic       isSize3;
    logic [3:0] rp;
    logic       memStrobe;

    // Operands captured at decode for the write cycle
    aluOpE      aluOp;
    byteT       aluA;
    byteT       aluB;
    byteT       aluResult;
    flagsT      aluFlags;
    byteT       dst;
    logic       doWrite;
    logic       doFlags;
    logic       setCarry;
    logic       carryVal;

    byteT       dstAddr;
    byteT       rdDataA;
    byteT       rdDataB;
    byteT       immediate;
    aluOpE      decOp;
    byteT       decDst;
    logic       decWrite;
    logic       decFlags;
    logic       decCarry;
    coreStateE  decNext;
    logic       condition;
    logic       takeBranch;
    addrT       relTarget;
    logic       flagsWrite;
    flagsT      flagsNew;

    function automatic byteT mapReg(input byteT r, input logic [3:0] ptr);
        if (r[7:4] == WORKING_PREFIX) begin
            return {ptr, r[3:0]};
        end
        return r;
    endfunction

    assign instrH  = instr[7:4];
    assign instrL  = instr[3:0];
    assign isSize1 = (instrL[3:1] == 3'b111);
    assign isSize3 = (instrL[3:2] == 2'b01) || (instrL == 4'hD);

    always_comb begin
        case (instrL)
        4'h2:    dstAddr = {rp, second[7:4]};
        4'h6:    dstAddr = mapReg(second, rp);
        default: dstAddr = {rp, instrH};
        endcase
    end

    assign immediate = (instrL == 4'h6) ? third : second;

    always_comb begin
        decOp    = aluLd;
        decDst   = dstAddr;
        decWrite = 1'b0;
        decFlags = 1'b0;
        decCarry = 1'b0;
        decNext  = stFetch;
        case (instrL)
        4'h1: begin
            // srp
            if (instrH == 4'h3) begin
                decDst   = REG_RP;
                decWrite = 1'b1;
                decNext  = stExecute;
            end
        end
        4'h2, 4'h6: begin
            if (instrH inside {[4'h0:4'h7], 4'hA, 4'hB}) begin
                decOp    = aluOpE'(instrH);
                // cp, tm and tcm only touch flags
                decWrite = !(instrH inside {4'h6, 4'h7, 4'hA});
                decFlags = 1'b1;
                decNext  = stExecute;
            end else if (instrL == 4'h6 && instrH == 4'hE) begin
                decWrite = 1'b1;
                decNext  = stExecute;
            end
        end
        4'hA: begin
            decOp    = aluDec;
            decWrite = 1'b1;
            decNext  = stDjnzDec;
        end
        4'hC: begin
            decWrite = 1'b1;
            decNext  = stExecute;
        end
        4'hE: begin
            decOp    = aluInc;
            decWrite = 1'b1;
            decFlags = 1'b1;
            decNext  = stExecute;
        end
        4'hF: begin
            // rcf, scf, ccf
            if (instrH inside {4'hC, 4'hD, 4'hE}) begin
                decFlags = 1'b1;
                decCarry = 1'b1;
                decNext  = stExecute;
            end
        end
        default: begin
        end
        endcase
    end

    always_comb begin
        case (instrH[2:0])
        3'd0: condition = 1'b0;
        3'd1: condition = flags.s ^ flags.v;
        3'd2: condition = (flags.s ^ flags.v) | flags.z;
        3'd3: condition = flags.c | flags.z;
        3'd4: condition = flags.v;
        3'd5: condition = flags.s;
        3'd6: condition = flags.z;
        3'd7: condition = flags.c;
        endcase
    end

    // Upper opcode bit selects the inverted condition
    assign takeBranch = condition ^ instrH[3];
    assign relTarget  = pc + {{8{second[7]}}, second};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= stFetch;
            pc       <= RESET_VECTOR;
            doWrite  <= 1'b0;
            doFlags  <= 1'b0;
            setCarry <= 1'b0;
        end else begin
            case (state)
            stFetch: begin
                state <= stReadInstr;
            end
            stReadInstr: begin
                pc    <= pc + 16'd1;
                state <= stWait2;
            end
            stWait2: begin
                state <= isSize1 ? stDecode : stRead2;
            end
            stRead2: begin
                pc    <= pc + 16'd1;
                state <= isSize3 ? stWait3 : stDecode;
            end
            stWait3: begin
                state <= stRead3;
            end
            stRead3: begin
                pc    <= pc + 16'd1;
                state <= stDecode;
            end
            stDecode: begin
                state    <= decNext;
                doWrite  <= decWrite;
                doFlags  <= decFlags;
                setCarry <= decCarry;
                if (takeBranch && instrL == 4'hB) begin
                    pc <= relTarget;
                end
                if (takeBranch && instrL == 4'hD) begin
                    pc <= {second, third};
                end
            end
            stDjnzDec: begin
                state <= stDjnzBranch;
            end
            stDjnzBranch: begin
                // aluA still holds the old count, so the ALU repeats the decrement
                if (aluResult != 8'h00) begin
                    pc <= relTarget;
                end
                state <= stFetch;
            end
            default: begin
                state <= stFetch;
            end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stReadInstr) begin
            instr <= rdData;
        end
        if (state == stRead2) begin
            second <= rdData;
        end
        if (state == stRead3) begin
            third <= rdData;
        end
        if (state == stDecode) begin
            aluOp    <= decOp;
            aluA     <= rdDataA;
            aluB     <= (instrL == 4'h2) ? rdDataB : immediate;
            dst      <= decDst;
            carryVal <= instrH[1] ? ~flags.c : instrH[0];
        end
    end

    // No fetch while reset is held
    assign fetchStrobe = rstN && (state == stFetch);
    assign memStrobe   = fetchStrobe || (state == stWait2 && !isSize1) || (state == stWait3);
    assign memReq      = '{strobe: memStrobe, addr: pc};

    assign regWrite = '{
        valid: doWrite && (state == stExecute || state == stDjnzDec),
        addr:  dst,
        data:  aluResult
    };

    assign flagsWrite = doFlags && (state == stExecute);

    always_comb begin
        flagsNew = aluFlags;
        if (setCarry) begin
            flagsNew.c = carryVal;
        end
    end

    z8Alu alu (
        .op       (aluOp),
        .a        (aluA),
        .b        (aluB),
        .flagsIn  (flags),
        .result   (aluResult),
        .flagsOut (aluFlags)
    );

    registerFile regFile (
        .clk        (clk),
        .rstN       (rstN),
        .rdAddrA    (dstAddr),
        .rdAddrB    ({rp, second[3:0]}),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .regWrite   (regWrite),
        .flagsWrite (flagsWrite),
        .flagsNew   (flagsNew),
        .rp         (rp),
        .flags      (flags)
    );

endmodule

// File: logic/z8Soc.sv
`timescale 1ns/10ps

module z8Soc
    import z8Pkg::*;
#(
    parameter int ROM_ADDR_BITS = 13
) (
    input  logic     clk,
    input  logic     rstN,
    input  romLoadT  romLoad,
    output regWriteT regWrite,
    output memReqT   fetch,
    output flagsT    flags
);
    memReqT memReq;
    byteT   romData;
    logic   fetchStrobe;

    programRom #(
        .ADDR_BITS (ROM_ADDR_BITS)
    ) rom (
        .clk     (clk),
        .memReq  (memReq),
        .rdData  (romData),
        .romLoad (romLoad)
    );

    z8Core core (
        .clk         (clk),
        .rstN        (rstN),
        .memReq      (memReq),
        .fetchStrobe (fetchStrobe),
        .rdData      (romData),
        .regWrite    (regWrite),
        .flags       (flags)
    );

    // Only opcode fetches, one per instruction
    assign fetch = '{strobe: memReq.strobe & fetchStrobe, addr: memReq.addr};

endmodule

// File: verification/z8RefModel.svh
`ifndef Z8_REF_MODEL_SVH
`define Z8_REF_MODEL_SVH

// Program image builder, image[0] sits at the reset vector

function automatic addrT here();
    return RESET_VECTOR + addrT'(image.size());
endfunction

function automatic void put(input byteT b);
    image.push_back(b);
endfunction

function automatic void loadWorking(input logic [3:0] r, input byteT value);
    put({r, 4'hC});
    put(value);
endfunction

function automatic void loadRegister(input byteT addr, input byteT value);
    put(8'hE6);
    put(addr);
    put(value);
endfunction

function automatic void setPointer(input logic [3:0] ptr);
    put(8'h31);
    put({ptr, 4'h0});
endfunction

function automatic void aluRegReg(input logic [3:0] op, input logic [3:0] r1,
                                  input logic [3:0] r2);
    put({op, 4'h2});
    put({r1, r2});
endfunction

function automatic void aluRegImm(input logic [3:0] op, input byteT addr, input byteT value);
    put({op, 4'h6});
    put(addr);
    put(value);
endfunction

// Offset is taken from the address after the 2-byte instruction
function automatic void jumpRel(input logic [3:0] cc, input addrT target);
    addrT off;
    off = target - (here() + 16'd2);
    put({cc, 4'hB});
    put(off[7:0]);
endfunction

function automatic void djnzTo(input logic [3:0] r, input addrT target);
    addrT off;
    off = target - (here() + 16'd2);
    put({r, 4'hA});
    put(off[7:0]);
endfunction

function automatic void jumpAbs(input logic [3:0] cc, input addrT target);
    put({cc, 4'hD});
    put(target[15:8]);
    put(target[7:0]);
endfunction

// jr always to itself
function automatic void endProgram();
    jumpRel(4'h8, here());
endfunction

// Instruction-level model

function automatic byteT progByte(input addrT a);
    int idx;
    idx = int'(a) - int'(RESET_VECTOR);
    if (idx >= 0 && idx < image.size()) begin
        return image[idx];
    end
    return 8'hFF;
endfunction

function automatic byteT mapWorking(input byteT addr);
    return (addr[7:4] == WORKING_PREFIX) ? {mRp, addr[3:0]} : addr;
endfunction

function automatic byteT readModelReg(input byteT addr);
    if (!addr[7]) begin
        return mRegs[addr[6:0]];
    end
    if (addr == REG_FLAGS) begin
        return mFlags;
    end
    if (addr == REG_RP) begin
        return {mRp, 4'h0};
    end
    return 8'h00;
endfunction

function automatic void writeModelReg(input byteT addr, input byteT data);
    expWrites.push_back('{valid: 1'b1, addr: addr, data: data});
    if (!addr[7]) begin
        mRegs[addr[6:0]] = data;
    end else if (addr == REG_FLAGS) begin
        mFlags = flagsT'({data[7:4], 2'b00, data[1:0]});
    end else if (addr == REG_RP) begin
        mRp = data[7:4];
    end
endfunction

function automatic byteT refAlu(input logic [3:0] op, input byteT a, input byteT b);
    int   cin;
    int   wide;
    int   sgn;
    byteT res;
    cin = (op == 4'h1 || op == 4'h3) ? int'(mFlags.c) : 0;
    wide = 0;
    sgn = 0;
    case (op)
    4'h0, 4'h1: begin
        wide = int'(a) + int'(b) + cin;
        sgn  = int'($signed(a)) + int'($signed(b)) + cin;
    end
    4'h2, 4'h3, 4'hA: begin
        wide = int'(a) - int'(b) - cin;
        sgn  = int'($signed(a)) - int'($signed(b)) - cin;
    end
    4'h4: res = a | b;
    4'h6: res = (~a) & b;
    4'hB: res = a ^ b;
    default: res = a & b;
    endcase
    if (op inside {4'h0, 4'h1, 4'h2, 4'h3, 4'hA}) begin
        res = wide[7:0];
        // Carry out on add, borrow on subtract
        mFlags.c = (wide > 255) || (wide < 0);
        mFlags.v = (sgn > 127) || (sgn < -128);
    end else begin
        mFlags.v = 1'b0;
    end
    mFlags.z = (res == 8'h00);
    mFlags.s = res[7];
    mFlags.d = 1'b0;
    mFlags.h = 1'b0;
    return res;
endfunction

function automatic logic conditionMet(input logic [3:0] cc);
    logic cond;
    case (cc[2:0])
    3'd0: cond = 1'b0;
    3'd1: cond = mFlags.s ^ mFlags.v;
    3'd2: cond = (mFlags.s ^ mFlags.v) | mFlags.z;
    3'd3: cond = mFlags.c | mFlags.z;
    3'd4: cond = mFlags.v;
    3'd5: cond = mFlags.s;
    3'd6: cond = mFlags.z;
    default: cond = mFlags.c;
    endcase
    return cond ^ cc[3];
endfunction

function automatic void runModel();
    addrT       pc;
    addrT       next;
    byteT       op;
    byteT       b2;
    byteT       b3;
    byteT       dst;
    byteT       val;
    byteT       res;
    logic [3:0] hi;
    logic [3:0] lo;
    expFetch.delete();
    expWrites.delete();
    foreach (mRegs[i]) begin
        mRegs[i] = 8'h00;
    end
    mRp = 4'h0;
    mFlags = '0;
    pc = RESET_VECTOR;
    for (int step = 0; step < 5000; step++) begin
        expFetch.push_back(pc);
        op = progByte(pc);
        b2 = progByte(pc + 16'd1);
        b3 = progByte(pc + 16'd2);
        hi = op[7:4];
        lo = op[3:0];
        if (op == 8'h8B && b2 == 8'hFE) begin
            break;
        end
        if (lo inside {4'hE, 4'hF}) begin
            next = pc + 16'd1;
        end else if (lo inside {[4'h4:4'h7], 4'hD}) begin
            next = pc + 16'd3;
        end else begin
            next = pc + 16'd2;
        end
        case (lo)
        4'h1: begin
            if (hi == 4'h3) begin
                writeModelReg(REG_RP, b2);
            end
        end
        4'h2, 4'h6: begin
            if (hi inside {[4'h0:4'h7], 4'hA, 4'hB}) begin
                dst = (lo == 4'h2) ? {mRp, b2[7:4]} : mapWorking(b2);
                val = (lo == 4'h2) ? readModelReg({mRp, b2[3:0]}) : b3;
                res = refAlu(hi, readModelReg(dst), val);
                // cp, tm and tcm leave the destination alone
                if (!(hi inside {4'h6, 4'h7, 4'hA})) begin
                    writeModelReg(dst, res);
                end
            end else if (lo == 4'h6 && hi == 4'hE) begin
                writeModelReg(mapWorking(b2), b3);
            end
        end
        4'hA: begin
            dst = {mRp, hi};
            val = readModelReg(dst) - 8'd1;
            writeModelReg(dst, val);
            if (val != 8'h00) begin
                next = next + {{8{b2[7]}}, b2};
            end
        end
        4'hB: begin
            if (conditionMet(hi)) begin
                next = next + {{8{b2[7]}}, b2};
            end
        end
        4'hC: writeModelReg({mRp, hi}, b2);
        4'hD: begin
            if (conditionMet(hi)) begin
                next = {b2, b3};
            end
        end
        4'hE: begin
            dst = {mRp, hi};
            val = readModelReg(dst);
            res = val + 8'd1;
            mFlags.v = (val == 8'h7F);
            mFlags.z = (res == 8'h00);
            mFlags.s = res[7];
            mFlags.d = 1'b0;
            mFlags.h = 1'b0;
            writeModelReg(dst, res);
        end
        4'hF: begin
            if (hi inside {4'hC, 4'hD, 4'hE}) begin
                mFlags.c = (hi == 4'hE) ? ~mFlags.c : hi[0];
                mFlags.d = 1'b0;
                mFlags.h = 1'b0;
            end
        end
        default: begin
        end
        endcase
        pc = next;
    end
    expFlags = mFlags;
endfunction

`endif

// File: verification/z8Tb.sv
`timescale 1ns/10ps

module z8Tb
    import z8Pkg::*;
();
    localparam int CLK_PERIOD  = 20;
    localparam int RUN_TIMEOUT = 20000;

    logic     clk;
    logic     rstN;
    romLoadT  romLoad;
    regWriteT regWrite;
    memReqT   fetch;
    flagsT    flags;

    // Program image and expected results
    byteT     image [$];
    addrT     expFetch [$];
    regWriteT expWrites [$];
    flagsT    expFlags;

    // Model state
    byteT       mRegs [128];
    logic [3:0] mRp;
    flagsT      mFlags;

    logic checking;
    int   errors;
    int   testsRun;
    int   testsFailed;

    `include "z8RefModel.svh"

    z8Soc #(
        .ROM_ADDR_BITS (13)
    ) i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .romLoad  (romLoad),
        .regWrite (regWrite),
        .fetch    (fetch),
        .flags    (flags)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic compareAddr(input string name, input addrT got, input addrT exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compareWrite(input string name, input regWriteT got, input regWriteT exp);
        if (got !== exp) begin
            $display("ERR %s got addr %h data %h expected addr %h data %h",
                     name, got.addr, got.data, exp.addr, exp.data);
            errors++;
        end
    endtask

    task automatic compareFlags(input string name, input flagsT got, input flagsT exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Outputs change after the edge, so the edge sees settled values
    always @(posedge clk) begin
        if (!rstN && (fetch.strobe || regWrite.valid)) begin
            $display("fetch strobe or register write active while reset is held");
            errors++;
        end
        if (rstN && checking) begin
            if (fetch.strobe && expFetch.size() > 0) begin
                compareAddr("fetch.addr", fetch.addr, expFetch.pop_front());
            end
            if (regWrite.valid) begin
                if (expWrites.size() == 0) begin
                    $display("unexpected register write to %h with %h",
                             regWrite.addr, regWrite.data);
                    errors++;
                end else begin
                    compareWrite("regWrite", regWrite, expWrites.pop_front());
                end
            end
        end
    end

    task automatic runProgram(input string name);
        int errorsBefore;
        int guard;
        errorsBefore = errors;
        runModel();
        @(posedge clk);
        rstN <= 1'b0;
        checking <= 1'b0;
        foreach (image[i]) begin
            @(posedge clk);
            romLoad <= '{en: 1'b1, addr: RESET_VECTOR + addrT'(i), data: image[i]};
        end
        @(posedge clk);
        romLoad <= '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        checking <= 1'b1;
        guard = 0;
        while (expFetch.size() != 0 && guard < RUN_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (expFetch.size() != 0) begin
            $display("timeout in %s with %0d fetches never seen", name, expFetch.size());
            errors++;
        end else begin
            if (expWrites.size() != 0) begin
                $display("%s ended with %0d register writes missing", name, expWrites.size());
                errors++;
            end
            compareFlags("flags", flags, expFlags);
        end
        @(posedge clk);
        checking <= 1'b0;
        testsRun++;
        if (errors == errorsBefore) begin
            $display("test %-9s ok", name);
        end else begin
            testsFailed++;
            $display("test %-9s fail, %0d errors", name, errors - errorsBefore);
        end
    endtask

    function automatic byteT randByte();
        return byteT'($urandom);
    endfunction

    function automatic byteT carryOp();
        int pick;
        pick = $urandom % 3;
        return (pick == 0) ? 8'hCF : (pick == 1) ? 8'hDF : 8'hEF;
    endfunction

    task automatic buildAluTest();
        logic [3:0] op;
        logic [3:0] r1;
        logic [3:0] r2;
        image.delete();
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 10; k++) begin
                op = (k < 8) ? 4'(k) : 4'(k + 2);
                r1 = 4'($urandom % 16);
                r2 = 4'((r1 + 1 + $urandom % 15) % 16);
                loadWorking(r1, randByte());
                loadWorking(r2, randByte());
                put(($urandom % 2) ? 8'hDF : 8'hCF);
                aluRegReg(op, r1, r2);
                // Flags copied out through a register write
                aluRegImm(4'h4, REG_FLAGS, 8'h00);
                if (round == 0) begin
                    loadWorking(r1, randByte());
                    aluRegImm(op, {WORKING_PREFIX, r1}, randByte());
                end else begin
                    loadRegister({4'h4, r1}, randByte());
                    aluRegImm(op, {4'h4, r1}, randByte());
                end
                aluRegImm(4'h4, REG_FLAGS, 8'h00);
            end
        end
        endProgram();
    endtask

    task automatic buildLoadTest();
        logic [3:0] r;
        image.delete();
        for (int i = 0; i < 6; i++) begin
            setPointer(4'($urandom % 8));
            r = 4'($urandom % 16);
            loadWorking(r, randByte());
            loadRegister({WORKING_PREFIX, r ^ 4'h1}, randByte());
            put({r, 4'hE});
            loadRegister(8'h60 + byteT'(i), randByte());
        end
        // Increment across the signed limit sets V
        loadWorking(4'h2, 8'h7F);
        put(8'h2E);
        endProgram();
    endtask

    task automatic buildDjnzTest();
        addrT loopTop;
        image.delete();
        setPointer(4'h3);
        loadWorking(4'h6, 8'h00);
        loadWorking(4'h5, byteT'(2 + $urandom % 5));
        loopTop = here();
        put(8'h6E);
        djnzTo(4'h5, loopTop);
        // Count of one falls through
        loadWorking(4'h5, 8'h01);
        djnzTo(4'h5, here());
        endProgram();
    endtask

    task automatic buildBranchTest();
        image.delete();
        for (int cc = 0; cc < 16; cc++) begin
            for (int rep = 0; rep < 2; rep++) begin
                loadRegister(REG_FLAGS, randByte() & 8'hF0);
                jumpRel(4'(cc), here() + 16'd4);
                loadWorking(4'h1, byteT'(cc));
                loadRegister(REG_FLAGS, randByte() & 8'hF0);
                jumpAbs(4'(cc), here() + 16'd5);
                loadWorking(4'h2, byteT'(cc));
            end
        end
        endProgram();
    endtask

    task automatic buildCarryTest();
        image.delete();
        setPointer(4'h1);
        for (int i = 0; i < 8; i++) begin
            loadRegister(REG_FLAGS, randByte() & 8'hF0);
            put(carryOp());
            loadWorking(4'h2, randByte());
            loadWorking(4'h3, randByte());
            aluRegReg(4'h1, 4'h2, 4'h3);
        end
        loadRegister(REG_FLAGS, randByte() & 8'hF0);
        put(8'hEF);
        put(carryOp());
        endProgram();
    endtask

    initial begin
        rstN = 1'b0;
        romLoad = '0;
        checking = 1'b0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        void'($urandom(32'hc642_bd64));

        image.delete();
        put(8'hFF);
        endProgram();
        runProgram("resetVec");
        buildAluTest();
        runProgram("aluOps");
        buildLoadTest();
        runProgram("loadRp");
        buildDjnzTest();
        runProgram("djnz");
        buildBranchTest();
        runProgram("branches");
        buildCarryTest();
        runProgram("carryOps");

        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verification
logic/z8Pkg.sv
logic/programRom.sv
logic/z8Alu.sv
logic/registerFile.sv
logic/z8Core.sv
logic/z8Soc.sv
verification/z8Tb.sv

// File: Bender.yml
package:
  name: z8

sources:
  - logic/z8Pkg.sv
  - logic/programRom.sv
  - logic/z8Alu.sv
  - logic/registerFile.sv
  - logic/z8Core.sv
  - logic/z8Soc.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/z8Tb.sv
